//--- axil_reg_bank.f
design/axil_regs_pkg.sv
design/axil_write_ctrl.sv
design/axil_read_ctrl.sv
design/axil_reg_file.sv
design/axil_reg_bank.sv
verification/axil_reg_bank_checker.sv
verification/axil_reg_bank_tb.sv

//--- design/axil_read_ctrl.sv
module axil_read_ctrl (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  axil_regs_pkg::addr_t                s_axi_araddr,
  input  logic                                s_axi_arvalid,
  output logic                                s_axi_arready,
  output logic [axil_regs_pkg::DATA_WIDTH-1:0] s_axi_rdata,
  output axil_regs_pkg::resp_t                s_axi_rresp,
  output logic                                s_axi_rvalid,
  input  logic                                s_axi_rready,
  output axil_regs_pkg::reg_index_t           reg_rd_index,
  input  logic [axil_regs_pkg::DATA_WIDTH-1:0] reg_rd_data
);

  import axil_regs_pkg::*;

  // Read address captured on acceptance
  addr_t araddr_q;

  // High in the cycle the selected word is loaded into rdata
  logic rd_load;

  // --------------------
  // AR acceptance
  // --------------------

  // arready pulses for one cycle per valid address
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_arready <= 1'b0;
    end else if (!s_axi_arready && s_axi_arvalid) begin
      s_axi_arready <= 1'b1;
    end else begin
      s_axi_arready <= 1'b0;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!s_axi_arready && s_axi_arvalid) begin
      araddr_q <= s_axi_araddr;
    end
  end

  // The register file decodes the latched address during the ready cycle
  assign reg_rd_index = araddr_q[ADDR_LSB +: REG_INDEX_BITS];

  // --------------------
  // R response
  // --------------------

  // Load only when nothing is pending, so held data is never overwritten
  assign rd_load = s_axi_arready && s_axi_arvalid && !s_axi_rvalid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_rvalid <= 1'b0;
      s_axi_rresp  <= RESP_OKAY;
    end else if (rd_load) begin
      s_axi_rvalid <= 1'b1;
      s_axi_rresp  <= RESP_OKAY;
    end else if (s_axi_rvalid && s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // Read data register, cleared so the bus is quiet after reset
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_rdata <= '0;
    end else if (rd_load) begin
      s_axi_rdata <= reg_rd_data;
    end
  end

  // Under back-pressure the whole R beat stays put
  a_r_stable : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

//--- design/axil_reg_bank.sv
module axil_reg_bank (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  // Write address channel
  input  axil_regs_pkg::addr_t                s_axi_awaddr,
  input  logic                                s_axi_awvalid,
  output logic                                s_axi_awready,
  // Write data channel
  input  logic [axil_regs_pkg::DATA_WIDTH-1:0] s_axi_wdata,
  input  axil_regs_pkg::strb_t                s_axi_wstrb,
  input  logic                                s_axi_wvalid,
  output logic                                s_axi_wready,
  // Write response channel
  output axil_regs_pkg::resp_t                s_axi_bresp,
  output logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  // Read address channel
  input  axil_regs_pkg::addr_t                s_axi_araddr,
  input  logic                                s_axi_arvalid,
  output logic                                s_axi_arready,
  // Read data channel
  output logic [axil_regs_pkg::DATA_WIDTH-1:0] s_axi_rdata,
  output axil_regs_pkg::resp_t                s_axi_rresp,
  output logic                                s_axi_rvalid,
  input  logic                                s_axi_rready,
  // Registers 0 to 8, register 0 in the top word
  output logic [axil_regs_pkg::NUM_EXPORT_REGS*axil_regs_pkg::DATA_WIDTH-1:0] regs_out
);

  import axil_regs_pkg::*;

  // Write path into the register file
  logic                  reg_wr_en;
  reg_index_t            reg_wr_index;
  logic [DATA_WIDTH-1:0] reg_wr_data;
  strb_t                 reg_wr_strb;

  // Read path, the index goes in and the word comes back the same cycle
  reg_index_t            reg_rd_index;
  logic [DATA_WIDTH-1:0] reg_rd_data;

  axil_write_ctrl i_axil_write_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .reg_wr_en     (reg_wr_en),
    .reg_wr_index  (reg_wr_index),
    .reg_wr_data   (reg_wr_data),
    .reg_wr_strb   (reg_wr_strb)
  );

  axil_read_ctrl i_axil_read_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .reg_rd_index  (reg_rd_index),
    .reg_rd_data   (reg_rd_data)
  );

  axil_reg_file i_axil_reg_file (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .reg_wr_en     (reg_wr_en),
    .reg_wr_index  (reg_wr_index),
    .reg_wr_data   (reg_wr_data),
    .reg_wr_strb   (reg_wr_strb),
    .reg_rd_index  (reg_rd_index),
    .reg_rd_data   (reg_rd_data),
    .regs_out      (regs_out)
  );

endmodule

//--- design/axil_reg_file.sv
module axil_reg_file (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic                                reg_wr_en,
  input  axil_regs_pkg::reg_index_t           reg_wr_index,
  input  logic [axil_regs_pkg::DATA_WIDTH-1:0] reg_wr_data,
  input  axil_regs_pkg::strb_t                reg_wr_strb,
  input  axil_regs_pkg::reg_index_t           reg_rd_index,
  output logic [axil_regs_pkg::DATA_WIDTH-1:0] reg_rd_data,
  output logic [axil_regs_pkg::NUM_EXPORT_REGS*axil_regs_pkg::DATA_WIDTH-1:0] regs_out
);

  import axil_regs_pkg::*;

  // --------------------
  // Storage
  // --------------------

  // The register array, indexed by register number
  data_word_t regs_q [NUM_REGS];

  // Incoming write word, looked at lane by lane for the strobe merge
  data_word_t wr_word;

  assign wr_word.word = reg_wr_data;

  // Every register comes out of reset as zero
  // On a write only the lanes with their strobe bit set take new data,
  // the others keep what they held
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (reg_wr_en) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (reg_wr_strb[b]) begin
          regs_q[reg_wr_index].bytes[b] <= wr_word.bytes[b];
        end
      end
    end
  end

  // --------------------
  // Read side
  // --------------------

  // All index values map to a register, so no default word is needed
  assign reg_rd_data = regs_q[reg_rd_index].word;

  // Export bus with register 0 in the top word and the last exported
  // register in the bottom word
  for (genvar i = 0; i < NUM_EXPORT_REGS; i++) begin : g_export
    assign regs_out[(NUM_EXPORT_REGS-1-i)*DATA_WIDTH +: DATA_WIDTH] = regs_q[i].word;
  end

  // Strobes come straight from the bus through the write controller
  // and must be resolved whenever a write lands here
  a_strb_known : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    reg_wr_en |-> !$isunknown(reg_wr_strb));

endmodule

//--- design/axil_regs_pkg.sv
package axil_regs_pkg;

  // --------------------
  // Bus geometry
  // --------------------

  // Width of the AXI4-Lite data bus
  localparam int DATA_WIDTH = 32;

  // Width of the AXI4-Lite address bus, enough for 32 word registers
  localparam int ADDR_WIDTH = 7;

  // One strobe bit per byte lane of the data bus
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // --------------------
  // Register map
  // --------------------

  // Address bits below this one pick a byte within the word and are ignored
  localparam int ADDR_LSB = 2;

  // Address bits above ADDR_LSB that pick the register
  localparam int REG_INDEX_BITS = 5;

  // Full register space, one register per index value
  localparam int NUM_REGS = 1 << REG_INDEX_BITS;

  // Registers 0 up to this count minus one also leave on the export bus
  localparam int NUM_EXPORT_REGS = 9;

  // The slave never reports an error, so OKAY is the only code in use
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // --------------------
  // Types
  // --------------------

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef logic [REG_INDEX_BITS-1:0] reg_index_t;
  typedef logic [1:0]                resp_t;

  // A register word seen either whole or as byte lanes
  // The byte view lines up lane n with strobe bit n
  typedef union packed {
    logic [DATA_WIDTH-1:0]          word;
    logic [STRB_WIDTH-1:0][7:0]     bytes;
  } data_word_t;

endpackage

//--- design/axil_write_ctrl.sv
module axil_write_ctrl (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  axil_regs_pkg::addr_t                s_axi_awaddr,
  input  logic                                s_axi_awvalid,
  output logic                                s_axi_awready,
  input  logic [axil_regs_pkg::DATA_WIDTH-1:0] s_axi_wdata,
  input  axil_regs_pkg::strb_t                s_axi_wstrb,
  input  logic                                s_axi_wvalid,
  output logic                                s_axi_wready,
  output axil_regs_pkg::resp_t                s_axi_bresp,
  output logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  output logic                                reg_wr_en,
  output axil_regs_pkg::reg_index_t           reg_wr_index,
  output logic [axil_regs_pkg::DATA_WIDTH-1:0] reg_wr_data,
  output axil_regs_pkg::strb_t                reg_wr_strb
);

  import axil_regs_pkg::*;

  // Write address captured when the transfer is accepted
  addr_t awaddr_q;

  // --------------------
  // AW and W acceptance
  // --------------------

  // Address and data are taken together, so both readies pulse for one
  // cycle once both valids are seen
  // There is no queue here and the master is expected to wait for B
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_awready <= 1'b0;
    end else if (!s_axi_awready && s_axi_awvalid && s_axi_wvalid) begin
      s_axi_awready <= 1'b1;
    end else begin
      s_axi_awready <= 1'b0;
    end
  end

  // wready follows the same condition as awready in a flop of its own
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_wready <= 1'b0;
    end else if (!s_axi_wready && s_axi_wvalid && s_axi_awvalid) begin
      s_axi_wready <= 1'b1;
    end else begin
      s_axi_wready <= 1'b0;
    end
  end

  // The address is latched on the same condition that raises the readies
  always_ff @(posedge S_AXI_ACLK) begin
    if (!s_axi_awready && s_axi_awvalid && s_axi_wvalid) begin
      awaddr_q <= s_axi_awaddr;
    end
  end

  // --------------------
  // Register file write
  // --------------------

  // Write fires in the ready cycle while both valids are still held
  assign reg_wr_en    = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;
  assign reg_wr_index = awaddr_q[ADDR_LSB +: REG_INDEX_BITS];
  // Data and strobes are still on the bus during the ready cycle
  assign reg_wr_data  = s_axi_wdata;
  assign reg_wr_strb  = s_axi_wstrb;

  // --------------------
  // B response
  // --------------------

  // The response rises with the register update and waits for bready
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s_axi_bvalid <= 1'b0;
      s_axi_bresp  <= RESP_OKAY;
    end else if (reg_wr_en && !s_axi_bvalid) begin
      s_axi_bvalid <= 1'b1;
      s_axi_bresp  <= RESP_OKAY;
    end else if (s_axi_bvalid && s_axi_bready) begin
      s_axi_bvalid <= 1'b0;
    end
  end

  // Both readies are high together and only while the master still holds
  // both valids, since the write enable needs all four in the ready cycle
  a_ready_pair : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (s_axi_awready || s_axi_wready) |->
      (s_axi_awready && s_axi_wready && s_axi_awvalid && s_axi_wvalid));

  // A pending response is held until the master takes it
  a_bvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the register bank testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

{ verilator --binary --timing --assert \
    --top-module axil_reg_bank_tb \
    -f axil_reg_bank.f \
    -o axil_reg_bank_sim \
  && ./obj_dir/axil_reg_bank_sim; } > "$LOG" 2>&1 \
  || echo "Build or simulation ended with an error status"

cat "$LOG"

grep -qx "RESULT: PASS" "$LOG" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- verification/axil_reg_bank_checker.sv
module axil_reg_bank_checker (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  axil_regs_pkg::addr_t                s_axi_awaddr,
  input  logic                                s_axi_awvalid,
  input  logic                                s_axi_awready,
  input  logic [axil_regs_pkg::DATA_WIDTH-1:0] s_axi_wdata,
  input  axil_regs_pkg::strb_t                s_axi_wstrb,
  input  logic                                s_axi_wvalid,
  input  logic                                s_axi_wready,
  input  axil_regs_pkg::resp_t                s_axi_bresp,
  input  logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  input  axil_regs_pkg::addr_t                s_axi_araddr,
  input  logic                                s_axi_arvalid,
  input  logic                                s_axi_arready,
  input  logic [axil_regs_pkg::DATA_WIDTH-1:0] s_axi_rdata,
  input  axil_regs_pkg::resp_t                s_axi_rresp,
  input  logic                                s_axi_rvalid,
  input  logic                                s_axi_rready,
  input  logic [axil_regs_pkg::NUM_EXPORT_REGS*axil_regs_pkg::DATA_WIDTH-1:0] regs_out,
  // Value the stimulus table expects from the read in flight
  input  logic [axil_regs_pkg::DATA_WIDTH-1:0] expect_rdata,
  output int                                  error_count
);

  timeunit 1ns;
  timeprecision 1ps;

  import axil_regs_pkg::*;

  // Shadow of the register array, built only from observed W handshakes
  logic [DATA_WIDTH-1:0] shadow [NUM_REGS];

  // Register addressed by the read that is in flight
  reg_index_t rd_index_q;

  // Flags carried from one clock edge to the next
  logic rst_seen_q = 1'b0;
  logic wr_done_q  = 1'b0;
  logic bhold_q    = 1'b0;
  logic rhold_q    = 1'b0;
  logic [DATA_WIDTH-1:0] rdata_q;

  int errors = 0;

  assign error_count = errors;

  // Byte lanes with a set strobe take the new data and the rest stay
  function automatic logic [DATA_WIDTH-1:0] merge_lanes(input logic [DATA_WIDTH-1:0] old_word,
                                                        input logic [DATA_WIDTH-1:0] new_word,
                                                        input strb_t strb);
    logic [DATA_WIDTH-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // --------------------
  // Post-reset state
  // --------------------

  // Every handshake output is quiet and the responses read as zero
  task automatic check_idle();
    compare_word("s_axi_awready", '0, 32'(s_axi_awready));
    compare_word("s_axi_wready", '0, 32'(s_axi_wready));
    compare_word("s_axi_bvalid", '0, 32'(s_axi_bvalid));
    compare_word("s_axi_arready", '0, 32'(s_axi_arready));
    compare_word("s_axi_rvalid", '0, 32'(s_axi_rvalid));
    compare_word("s_axi_bresp", '0, 32'(s_axi_bresp));
    compare_word("s_axi_rresp", '0, 32'(s_axi_rresp));
    compare_word("s_axi_rdata", '0, s_axi_rdata);
  endtask

  // Register 0 sits in the top word of the export bus
  task automatic check_export();
    for (int i = 0; i < NUM_EXPORT_REGS; i++) begin
      compare_word($sformatf("regs_out[%0d]", i), shadow[i],
                   regs_out[(NUM_EXPORT_REGS-1-i)*DATA_WIDTH +: DATA_WIDTH]);
    end
  endtask

  // --------------------
  // Sampling
  // --------------------

  // All values seen here are the ones held during the cycle before the edge
  always @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        shadow[r] <= '0;
      end
      rst_seen_q <= 1'b1;
      wr_done_q  <= 1'b0;
      bhold_q    <= 1'b0;
      rhold_q    <= 1'b0;
    end else begin
      if (rst_seen_q) begin
        check_idle();
      end
      // The export bus has caught up with the write of the previous edge
      if (rst_seen_q || wr_done_q) begin
        check_export();
      end
      // A response under back-pressure must still be there with its data unchanged
      if (bhold_q) begin
        compare_word("s_axi_bvalid", 32'd1, 32'(s_axi_bvalid));
      end
      if (rhold_q) begin
        compare_word("s_axi_rvalid", 32'd1, 32'(s_axi_rvalid));
        compare_word("s_axi_rdata (held)", rdata_q, s_axi_rdata);
      end
      if (s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready) begin
        shadow[s_axi_awaddr[ADDR_LSB +: REG_INDEX_BITS]] <=
          merge_lanes(shadow[s_axi_awaddr[ADDR_LSB +: REG_INDEX_BITS]], s_axi_wdata, s_axi_wstrb);
      end
      if (s_axi_bvalid && s_axi_bready) begin
        compare_word("s_axi_bresp", 32'(RESP_OKAY), 32'(s_axi_bresp));
      end
      if (s_axi_arvalid && s_axi_arready) begin
        rd_index_q <= s_axi_araddr[ADDR_LSB +: REG_INDEX_BITS];
      end
      // Read data is judged twice, once against the shadow and once against the table
      if (s_axi_rvalid && s_axi_rready) begin
        compare_word("s_axi_rresp", 32'(RESP_OKAY), 32'(s_axi_rresp));
        compare_word("s_axi_rdata (model)", shadow[rd_index_q], s_axi_rdata);
        compare_word("s_axi_rdata (table)", expect_rdata, s_axi_rdata);
      end
      rst_seen_q <= 1'b0;
      wr_done_q  <= s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready;
      bhold_q    <= s_axi_bvalid && !s_axi_bready;
      rhold_q    <= s_axi_rvalid && !s_axi_rready;
      rdata_q    <= s_axi_rdata;
    end
  end

endmodule

//--- verification/axil_reg_bank_tb.sv
module axil_reg_bank_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import axil_regs_pkg::*;

  // Cycles any single wait may take before the run is given up
  localparam int WAIT_LIMIT = 50;

  localparam logic WR = 1'b1;
  localparam logic RD = 1'b0;

  // One line of the stimulus table
  typedef struct packed {
    logic                  is_write;
    addr_t                 addr;
    logic [DATA_WIDTH-1:0] data;
    strb_t                 strb;
    logic [DATA_WIDTH-1:0] rd_value;
  } step_t;

  logic                  S_AXI_ACLK;
  logic                  S_AXI_ARESETN;
  addr_t                 s_axi_awaddr;
  logic                  s_axi_awvalid;
  logic                  s_axi_awready;
  logic [DATA_WIDTH-1:0] s_axi_wdata;
  strb_t                 s_axi_wstrb;
  logic                  s_axi_wvalid;
  logic                  s_axi_wready;
  resp_t                 s_axi_bresp;
  logic                  s_axi_bvalid;
  logic                  s_axi_bready;
  addr_t                 s_axi_araddr;
  logic                  s_axi_arvalid;
  logic                  s_axi_arready;
  logic [DATA_WIDTH-1:0] s_axi_rdata;
  resp_t                 s_axi_rresp;
  logic                  s_axi_rvalid;
  logic                  s_axi_rready;
  logic [NUM_EXPORT_REGS*DATA_WIDTH-1:0] regs_out;

  logic [DATA_WIDTH-1:0] expect_rdata;
  int                    check_errors;
  int                    timeout_count = 0;
  logic                  timed_out = 1'b0;
  logic [31:0]           rng_state = 32'hff16_e916;
  step_t                 steps [$];

  axil_reg_bank i_axil_reg_bank (.*);

  axil_reg_bank_checker i_axil_reg_bank_checker (
    .expect_rdata (expect_rdata),
    .error_count  (check_errors),
    .*
  );

  always #50 S_AXI_ACLK = ~S_AXI_ACLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Back-pressure of 0 to 5 cycles on B and R
  function automatic int random_hold();
    rng_state = xorshift32(rng_state);
    return int'(rng_state % 32'd6);
  endfunction

  function automatic step_t make_step(input logic is_write, input addr_t addr,
                                      input logic [DATA_WIDTH-1:0] data, input strb_t strb,
                                      input logic [DATA_WIDTH-1:0] rd_value);
    step_t s;
    s = '{is_write, addr, data, strb, rd_value};
    return s;
  endfunction

  // Codes 0 to 3 pick awready, bvalid, arready or rvalid
  task automatic wait_for_output(input logic [1:0] which, input string what);
    logic seen;
    int   cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(posedge S_AXI_ACLK);
      case (which)
        2'd0: seen = s_axi_awready;
        2'd1: seen = s_axi_bvalid;
        2'd2: seen = s_axi_arready;
        2'd3: seen = s_axi_rvalid;
      endcase
      cycles++;
    end
    if (!seen) begin
      $display("Timeout: %s did not rise within %0d cycles", what, WAIT_LIMIT);
      timed_out = 1'b1;
      timeout_count++;
    end
  endtask

  // --------------------
  // Transactions
  // --------------------

  task automatic write_register(input addr_t addr, input logic [DATA_WIDTH-1:0] data,
                                input strb_t strb);
    int hold;
    @(posedge S_AXI_ACLK);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
    wait_for_output(2'd0, "awready");
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    if (!timed_out) begin
      wait_for_output(2'd1, "bvalid");
    end
    if (!timed_out) begin
      hold = random_hold();
      repeat (hold) @(posedge S_AXI_ACLK);
      s_axi_bready <= 1'b1;
      // bvalid is already up, so the response is taken at the next edge
      @(posedge S_AXI_ACLK);
      s_axi_bready <= 1'b0;
    end
  endtask

  task automatic read_register(input addr_t addr, input logic [DATA_WIDTH-1:0] rd_value);
    int hold;
    @(posedge S_AXI_ACLK);
    expect_rdata  <= rd_value;
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    wait_for_output(2'd2, "arready");
    s_axi_arvalid <= 1'b0;
    if (!timed_out) begin
      wait_for_output(2'd3, "rvalid");
    end
    if (!timed_out) begin
      hold = random_hold();
      repeat (hold) @(posedge S_AXI_ACLK);
      s_axi_rready <= 1'b1;
      @(posedge S_AXI_ACLK);
      s_axi_rready <= 1'b0;
    end
  endtask

  initial begin
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    expect_rdata  = '0;

    // Reads of untouched registers, then full and partial strobe writes
    steps.push_back(make_step(RD, 7'h00, 32'h0, 4'h0, 32'h0000_0000));
    steps.push_back(make_step(RD, 7'h20, 32'h0, 4'h0, 32'h0000_0000));
    steps.push_back(make_step(RD, 7'h7C, 32'h0, 4'h0, 32'h0000_0000));
    steps.push_back(make_step(WR, 7'h00, 32'hDEAD_BEEF, 4'hF, 32'h0));
    steps.push_back(make_step(RD, 7'h00, 32'h0, 4'h0, 32'hDEAD_BEEF));
    steps.push_back(make_step(WR, 7'h04, 32'h1122_3344, 4'hF, 32'h0));
    steps.push_back(make_step(WR, 7'h04, 32'hAABB_CCDD, 4'h5, 32'h0));
    steps.push_back(make_step(RD, 7'h04, 32'h0, 4'h0, 32'h11BB_33DD));
    steps.push_back(make_step(WR, 7'h04, 32'hFFFF_FFFF, 4'h8, 32'h0));
    steps.push_back(make_step(RD, 7'h04, 32'h0, 4'h0, 32'hFFBB_33DD));
    // No strobe bit set leaves the register alone
    steps.push_back(make_step(WR, 7'h00, 32'h1234_5678, 4'h0, 32'h0));
    steps.push_back(make_step(RD, 7'h00, 32'h0, 4'h0, 32'hDEAD_BEEF));
    // Byte offset bits in the address select the same register
    steps.push_back(make_step(WR, 7'h23, 32'h0808_0808, 4'hF, 32'h0));
    steps.push_back(make_step(RD, 7'h21, 32'h0, 4'h0, 32'h0808_0808));
    steps.push_back(make_step(WR, 7'h24, 32'h9999_0009, 4'hF, 32'h0));
    steps.push_back(make_step(RD, 7'h24, 32'h0, 4'h0, 32'h9999_0009));
    steps.push_back(make_step(WR, 7'h7C, 32'h3131_3131, 4'hF, 32'h0));
    steps.push_back(make_step(RD, 7'h7E, 32'h0, 4'h0, 32'h3131_3131));
    steps.push_back(make_step(WR, 7'h20, 32'h0000_A500, 4'h2, 32'h0));
    steps.push_back(make_step(RD, 7'h20, 32'h0, 4'h0, 32'h0808_A508));
    steps.push_back(make_step(RD, 7'h08, 32'h0, 4'h0, 32'h0000_0000));

    repeat (4) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;

    for (int i = 0; i < steps.size(); i++) begin
      if (timed_out) begin
        break;
      end
      if (steps[i].is_write) begin
        write_register(steps[i].addr, steps[i].data, steps[i].strb);
      end else begin
        read_register(steps[i].addr, steps[i].rd_value);
      end
    end

    // Let the checker see the last export bus update
    repeat (2) @(posedge S_AXI_ACLK);
    $display("Closing counts: %0d check errors, %0d timeouts", check_errors, timeout_count);
    if (check_errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
